// ==== src.f ====
+incdir+source
source/psg_reg_pkg.sv
source/psg_audio_pkg.sv
source/psg_regs.sv
source/psg_voice_bank.sv
source/psg_mixer.sv
source/psg_stereo_top.sv
tests/psg_tb_clk.sv
tests/psg_tb.sv

// ==== Bender.yml ====
package:
  name: psg_stereo

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/psg_reg_pkg.sv
      - source/psg_audio_pkg.sv
      - source/psg_regs.sv
      - source/psg_voice_bank.sv
      - source/psg_mixer.sv
      - source/psg_stereo_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/psg_tb_clk.sv
      - tests/psg_tb.sv

// ==== tests/psg_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psg_settings.svh"

module psg_tb;
    import psg_reg_pkg::*;
    import psg_audio_pkg::*;

    localparam logic [31:0] SEED = 32'ha1017e9d;

    logic                  clk, rst, cen, cyc, stb, we, ack;
    logic [`PSG_WB_AW-1:0] adr;
    logic [`PSG_WB_DW-1:0] dat_i, dat_o;
    psg_sample_t           snd_l, snd_r;

    // Reference register files with index 0 left and 1 right
    logic [`PSG_PERIOD_W-1:0] ref_period [2][3];
    logic [`PSG_ATT_W-1:0]    ref_att    [2][4];
    logic [2:0]               ref_nctrl  [2];
    logic [1:0]               ref_chan   [2];   // Last latched channel
    logic                     ref_type   [2];

    int          n_mismatch = 0;
    int          n_timeout  = 0;
    logic        hold_en;                       // Watch one side for changes
    int          hold_side;
    psg_sample_t hold_val;

    psg_tb_clk i_clk (.clk, .rst);

    psg_stereo_top i_psg_stereo_top (
        .clk, .rst, .cen, .cyc, .stb, .we, .adr, .dat_i, .ack, .dat_o, .snd_l, .snd_r
    );

    function automatic psg_sample_t side_sample(input int s);
        return (s == 0) ? snd_l : snd_r;
    endfunction

    task automatic check_eq(input int got, input int exp, input string what);
        assert (got == exp) else begin
            n_mismatch++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_pm(input int s, input int amp, input string what);
        assert (side_sample(s) == amp || side_sample(s) == -amp) else begin
            n_mismatch++;
            $display("mismatch at %0t: %s is %0d, expected +/-%0d",
                     $time, what, side_sample(s), amp);
        end
    endtask

    task automatic report_timeout(input string what);
        n_timeout++;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    // One clock with inputs changing 1 ns later
    task automatic step();
        @(posedge clk);
        #1;
        if (hold_en) begin
            check_eq(side_sample(hold_side), hold_val, $sformatf("untouched side %0d", hold_side));
        end
    endtask

    // Chip byte format where bit 7 tells latch from data
    function automatic void model_write(input int c, input logic [7:0] b);
        if (b[7]) begin
            ref_chan[c] = b[6:5];
            ref_type[c] = b[4];
            if (b[4]) begin
                ref_att[c][b[6:5]] = b[3:0];
            end else if (b[6:5] == 2'd3) begin
                ref_nctrl[c] = b[2:0];
            end else begin
                ref_period[c][b[6:5]][3:0] = b[3:0];
            end
        end else if (!ref_type[c] && ref_chan[c] != 2'd3) begin
            ref_period[c][ref_chan[c]][9:4] = b[5:0];   // High bits of last tone
        end
    endfunction

    function automatic logic [15:0] expected_reg(input int c, input int idx);
        logic [15:0] r;
        r = '0;
        case (psg_reg_idx_t'(idx))
            REG_TONE0_PER:  r[9:0] = ref_period[c][0];
            REG_TONE0_ATT:  r[3:0] = ref_att[c][0];
            REG_TONE1_PER:  r[9:0] = ref_period[c][1];
            REG_TONE1_ATT:  r[3:0] = ref_att[c][1];
            REG_TONE2_PER:  r[9:0] = ref_period[c][2];
            REG_TONE2_ATT:  r[3:0] = ref_att[c][2];
            REG_NOISE_CTRL: r[2:0] = ref_nctrl[c];
            default:        r[3:0] = ref_att[c][3];
        endcase
        return r;
    endfunction

    // All tones held high and noise muted
    function automatic int dc_level(input int c);
        int sum;
        sum = 0;
        for (int v = 0; v < 3; v++) begin
            sum += psg_att_amp[ref_att[c][v]];
        end
        return sum;
    endfunction

    // Single request with handshake checks and the write taken on the ack edge
    task automatic bus_cycle(input logic wr, input int c, input int idx,
                             input logic [7:0] wdata, output logic [15:0] rdata);
        int n;
        step();
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = 4'(idx * 2 + c);
        dat_i = {8'($urandom), wdata};          // Upper byte is noise
        check_eq(ack, 0, "ack before request");
        n = 0;
        do begin
            step();
            n++;
        end while (!ack && n < 8);
        assert (ack) else report_timeout("bus request never acknowledged");
        check_eq(n, 1, "ack delay in cycles");
        rdata = dat_o;
        step();
        check_eq(ack, 0, "ack length");
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        if (wr && idx == 0) begin
            model_write(c, wdata);
        end
    endtask

    task automatic write_cmd(input int c, input logic [7:0] b);
        logic [15:0] unused_rd;
        bus_cycle(1'b1, c, 0, b, unused_rd);
    endtask

    task automatic set_period(input int c, input int v, input int p);
        psg_cmd_t    cmd;
        logic [9:0]  per;
        per     = 10'(p);
        cmd.lat = '{latch: 1'b1, chan: 2'(v), typ: PSG_TYPE_PER, data: per[3:0]};
        write_cmd(c, cmd);
        cmd.dat = '{latch: 1'b0, unused: 1'b0, data: per[9:4]};
        write_cmd(c, cmd);
    endtask

    task automatic set_att(input int c, input int v, input int a);
        psg_cmd_t cmd;
        cmd.lat = '{latch: 1'b1, chan: 2'(v), typ: PSG_TYPE_ATT, data: 4'(a)};
        write_cmd(c, cmd);
    endtask

    task automatic check_all_regs();
        logic [15:0] rd;
        for (int c = 0; c < 2; c++) begin
            for (int idx = 0; idx < 8; idx++) begin
                bus_cycle(1'b0, c, idx, 8'h00, rd);
                check_eq(rd, expected_reg(c, idx), $sformatf("chip %0d reg %0d", c, idx));
            end
        end
    endtask

    task automatic setup_dc(input int c);
        for (int v = 0; v < 3; v++) begin
            set_period(c, v, $urandom_range(0, 1));
            set_att(c, v, $urandom_range(0, 15));
        end
        set_att(c, 3, 15);
    endtask

    task automatic wait_level(input int s, input int exp, input int limit, input string what);
        int n;
        n = 0;
        while (side_sample(s) != exp && n < limit) begin
            step();
            n++;
        end
        assert (side_sample(s) == exp) else report_timeout(what);
    endtask

    initial begin
        logic [15:0] rd;
        psg_cmd_t    cmd;
        int          c, v, a, p, amp, n, k;
        bit          seen_pos, seen_neg;
        void'($urandom(SEED));
        cen = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_i = '0;
        hold_en = 1'b0;
        hold_side = 0;
        hold_val = '0;
        for (c = 0; c < 2; c++) begin
            ref_period[c] = '{default: '0};
            ref_att[c]    = '{default: 4'hf};   // Muted after reset
            ref_nctrl[c]  = '0;
            ref_chan[c]   = '0;
            ref_type[c]   = PSG_TYPE_PER;
        end

        // Random clock enable at half rate on average
        fork
            forever begin
                @(posedge clk);
                #1 cen = 1'($urandom_range(0, 1));
            end
        join_none

        n = 0;
        while (rst && n < 100) begin
            step();
            n++;
        end
        assert (!rst) else report_timeout("reset never released");

        // Silence and idle bus
        repeat (64) begin
            step();
            check_eq(snd_l, 0, "left sample after reset");
            check_eq(snd_r, 0, "right sample after reset");
            check_eq(ack, 0, "ack after reset");
        end

        // Held strobe acked every second cycle
        cyc = 1'b1;
        stb = 1'b1;
        adr = 4'b0010;                          // Tone0 attenuation of the left chip
        for (n = 1; n <= 10; n++) begin
            step();
            check_eq(ack, n % 2, "ack with held strobe");
            if (ack) begin
                check_eq(dat_o, expected_reg(0, 1), "read data with held strobe");
            end
        end
        cyc = 1'b0;
        repeat (4) begin                        // stb alone is no request
            step();
            check_eq(ack, 0, "ack without cyc");
        end
        stb = 1'b0;

        // Random command bytes with some writes off the command index
        for (n = 0; n < 200; n++) begin
            c = $urandom_range(0, 1);
            write_cmd(c, 8'($urandom));
            if ($urandom_range(0, 7) == 0) begin
                bus_cycle(1'b1, c, $urandom_range(1, 7), 8'($urandom), rd);
            end
            if (n % 50 == 49) begin
                check_all_regs();
            end
        end

        // DC levels while the other side must not move
        for (n = 0; n < 2; n++) begin
            setup_dc(n);
            wait_level(n, dc_level(n), 2000, $sformatf("steady level side %0d", n));
            hold_side = n;
            hold_val  = dc_level(n);
            hold_en   = 1'b1;
            setup_dc(1 - n);
            wait_level(1 - n, dc_level(1 - n), 2000,
                       $sformatf("steady level side %0d", 1 - n));
            hold_en   = 1'b0;
        end

        // One audible tone
        for (n = 0; n < 4; n++) begin
            c   = n % 2;
            v   = $urandom_range(0, 2);
            a   = $urandom_range(0, 14);
            p   = $urandom_range(2, 20);
            amp = psg_att_amp[a];
            for (k = 0; k < 4; k++) begin
                set_att(c, k, 15);
            end
            set_period(c, v, p);
            set_att(c, v, a);
            step();
            step();                             // Register then mixer
            seen_pos = 0;
            seen_neg = 0;
            k = 0;
            while (!(seen_pos && seen_neg) && k < 4000) begin
                check_pm(c, amp, "tone sample");
                seen_pos |= (side_sample(c) == amp);
                seen_neg |= (side_sample(c) == -amp);
                step();
                k++;
            end
            assert (seen_pos && seen_neg) else report_timeout("tone output never toggled");
        end

        // Noise alone at every rate in both feedback modes
        set_period(0, 2, 1);                    // Tone 2 steps on every tick
        set_period(1, 2, 1);
        for (n = 0; n < 8; n++) begin
            c   = $urandom_range(0, 1);
            a   = $urandom_range(0, 14);
            amp = psg_att_amp[a];
            for (v = 0; v < 3; v++) begin
                set_att(c, v, 15);
            end
            set_att(c, 3, a);
            cmd.lat = '{latch: 1'b1, chan: PSG_CHAN_NOISE, typ: PSG_TYPE_PER,
                        data: {1'b0, 1'(n / 4), 2'(n % 4)}};
            write_cmd(c, cmd);
            step();
            step();                             // Reseed pulse then mixer
            check_eq(side_sample(c), -amp, "noise right after reseed");
            k = 0;
            while (side_sample(c) != amp && k < 60000) begin
                check_pm(c, amp, "noise sample");
                step();
                k++;
            end
            assert (side_sample(c) == amp) else report_timeout("noise output never changed");
        end

        $display("Errors: %0d mismatches, %0d timeouts", n_mismatch, n_timeout);
        if (n_mismatch == 0 && n_timeout == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/psg_tb_clk.sv ====
`timescale 1ns/1ps
`default_nettype none

module psg_tb_clk (
    output logic clk,
    output logic rst
);
    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for the first 16 rising edges
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== source/psg_stereo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psg_settings.svh"

module psg_stereo_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [`PSG_WB_AW-1:0]      adr,
    input  logic [`PSG_WB_DW-1:0]      dat_i,
    output logic                       ack,
    output logic [`PSG_WB_DW-1:0]      dat_o,
    output psg_audio_pkg::psg_sample_t snd_l,
    output psg_audio_pkg::psg_sample_t snd_r
);
    // Left chip
    logic [`PSG_PERIOD_W-1:0] period0_l, period1_l, period2_l;
    logic [`PSG_ATT_W-1:0]    att0_l, att1_l, att2_l, att3_l;
    logic [2:0]               noise_ctrl_l;
    logic                     noise_wr_l;
    logic [3:0]               voice_l;
    // Right chip
    logic [`PSG_PERIOD_W-1:0] period0_r, period1_r, period2_r;
    logic [`PSG_ATT_W-1:0]    att0_r, att1_r, att2_r, att3_r;
    logic [2:0]               noise_ctrl_r;
    logic                     noise_wr_r;
    logic [3:0]               voice_r;

    psg_regs i_regs (
        .clk, .rst, .cyc, .stb, .we, .adr, .dat_i, .ack, .dat_o,
        .period0_l, .period1_l, .period2_l,
        .att0_l, .att1_l, .att2_l, .att3_l,
        .noise_ctrl_l, .noise_wr_l,
        .period0_r, .period1_r, .period2_r,
        .att0_r, .att1_r, .att2_r, .att3_r,
        .noise_ctrl_r, .noise_wr_r
    );

    psg_voice_bank i_bank_l (
        .clk, .rst, .cen,
        .period0    ( period0_l    ),
        .period1    ( period1_l    ),
        .period2    ( period2_l    ),
        .noise_ctrl ( noise_ctrl_l ),
        .noise_wr   ( noise_wr_l   ),
        .voice      ( voice_l      )
    );

    psg_voice_bank i_bank_r (
        .clk, .rst, .cen,
        .period0    ( period0_r    ),
        .period1    ( period1_r    ),
        .period2    ( period2_r    ),
        .noise_ctrl ( noise_ctrl_r ),
        .noise_wr   ( noise_wr_r   ),
        .voice      ( voice_r      )
    );

    psg_mixer i_mix_l (
        .clk, .rst,
        .voice ( voice_l ),
        .att0 ( att0_l ), .att1 ( att1_l ), .att2 ( att2_l ), .att3 ( att3_l ),
        .sample ( snd_l )
    );

    psg_mixer i_mix_r (
        .clk, .rst,
        .voice ( voice_r ),
        .att0 ( att0_r ), .att1 ( att1_r ), .att2 ( att2_r ), .att3 ( att3_r ),
        .sample ( snd_r )
    );

endmodule

`default_nettype wire

// ==== source/psg_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psg_settings.svh"

module psg_mixer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [3:0]                  voice,   // High means positive half
    input  logic [`PSG_ATT_W-1:0]       att0,
    input  logic [`PSG_ATT_W-1:0]       att1,
    input  logic [`PSG_ATT_W-1:0]       att2,
    input  logic [`PSG_ATT_W-1:0]       att3,    // Noise
    output psg_audio_pkg::psg_sample_t  sample
);
    import psg_audio_pkg::*;

    logic [`PSG_ATT_W-1:0] att   [4];
    psg_amp_t              amp   [4];
    psg_level_t            level [4];
    psg_sample_t           sum;

    assign att[0] = att0;
    assign att[1] = att1;
    assign att[2] = att2;
    assign att[3] = att3;

    always_comb begin
        sum = '0;
        for (int i = 0; i < 4; i++) begin
            amp[i] = psg_att_amp[att[i]];
            // Square wave around zero
            if (voice[i]) begin
                level[i] = psg_level_t'({1'b0, amp[i]});
            end else begin
                level[i] = -psg_level_t'({1'b0, amp[i]});
            end
            sum = sum + psg_sample_t'(level[i]);   // 4 x 511 still fits
        end
    end

    // One clock from voice bits to sample
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample <= '0;
        end else begin
            sample <= sum;
        end
    end

endmodule

`default_nettype wire

// ==== source/psg_voice_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psg_settings.svh"

module psg_voice_bank (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  logic [`PSG_PERIOD_W-1:0] period0,
    input  logic [`PSG_PERIOD_W-1:0] period1,
    input  logic [`PSG_PERIOD_W-1:0] period2,
    input  logic [2:0]               noise_ctrl,  // [2] white, [1:0] rate
    input  logic                     noise_wr,
    output logic [3:0]               voice        // Noise on bit 3
);
    localparam int PRE_W = $clog2(`PSG_PRESCALE);
    localparam logic [`PSG_LFSR_W-1:0] LFSR_SEED = {1'b1, {(`PSG_LFSR_W-1){1'b0}}};

    logic [PRE_W-1:0]         pre;
    logic                     tick;             // One voice step
    logic [`PSG_PERIOD_W-1:0] period [3];
    logic [`PSG_PERIOD_W-1:0] cnt    [3];
    logic [2:0]               tone;
    logic                     t2_reload;
    logic [5:0]               ndiv;
    logic [5:0]               nmask;
    logic                     nshift;
    logic [`PSG_LFSR_W-1:0]   lfsr;
    logic                     fb;

    assign period[0] = period0;
    assign period[1] = period1;
    assign period[2] = period2;

    // Divide cen down to the voice rate
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pre <= '0;
        end else if (tick) begin
            pre <= '0;
        end else if (cen) begin
            pre <= pre + 1'b1;
        end
    end

    assign tick = cen & (pre == PRE_W'(`PSG_PRESCALE - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                cnt[i]  <= '0;
                tone[i] <= 1'b1;
            end
        end else if (tick) begin
            for (int i = 0; i < 3; i++) begin
                if (period[i] < `PSG_PERIOD_W'(2)) begin
                    cnt[i]  <= '0;              // Too short, hold high
                    tone[i] <= 1'b1;
                end else if (cnt[i] == '0) begin
                    cnt[i]  <= period[i] - 1'b1;
                    tone[i] <= ~tone[i];        // Half period done
                end else begin
                    cnt[i] <= cnt[i] - 1'b1;
                end
            end
        end
    end

    // Tone 2 step, fires each tick while its period is 0 or 1
    assign t2_reload = tick & (cnt[2] == '0);

    always_comb begin
        case (noise_ctrl[1:0])
            2'd0:    nmask = 6'b001111;  // Every 16 ticks
            2'd1:    nmask = 6'b011111;
            default: nmask = 6'b111111;
        endcase
    end

    assign nshift = (noise_ctrl[1:0] == 2'd3) ? t2_reload
                                             : tick & ((ndiv & nmask) == nmask);
    assign fb     = noise_ctrl[2] ? (lfsr[0] ^ lfsr[1]) : lfsr[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ndiv <= '0;
            lfsr <= LFSR_SEED;
        end else if (noise_wr) begin
            ndiv <= '0;                         // Control write restarts noise
            lfsr <= LFSR_SEED;
        end else begin
            if (tick) begin
                ndiv <= ndiv + 1'b1;
            end
            if (nshift) begin
                lfsr <= {fb, lfsr[`PSG_LFSR_W-1:1]};
            end
        end
    end

    assign voice = {lfsr[0], tone};

endmodule

`default_nettype wire

// ==== source/psg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psg_settings.svh"

module psg_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [`PSG_WB_AW-1:0]    adr,
    input  logic [`PSG_WB_DW-1:0]    dat_i,
    output logic                     ack,
    output logic [`PSG_WB_DW-1:0]    dat_o,
    output logic [`PSG_PERIOD_W-1:0] period0_l, period1_l, period2_l,
    output logic [`PSG_ATT_W-1:0]    att0_l, att1_l, att2_l, att3_l,
    output logic [2:0]               noise_ctrl_l,
    output logic                     noise_wr_l,
    output logic [`PSG_PERIOD_W-1:0] period0_r, period1_r, period2_r,
    output logic [`PSG_ATT_W-1:0]    att0_r, att1_r, att2_r, att3_r,
    output logic [2:0]               noise_ctrl_r,
    output logic                     noise_wr_r
);
    import psg_reg_pkg::*;

    psg_cmd_t                 cmd;
    psg_reg_idx_t             rd_idx;
    logic                     chip;             // 0 left, 1 right
    logic                     req;
    logic                     wr;
    logic [`PSG_PERIOD_W-1:0] period [2][3];
    logic [`PSG_ATT_W-1:0]    att    [2][4];
    logic [2:0]               nctrl  [2];
    logic [1:0]               nwr;              // Reseed strobes
    logic [1:0]               lat_chan [2];     // Last latched channel per chip
    logic                     lat_type [2];
    logic [`PSG_WB_DW-1:0]    rd_data;

    assign cmd    = dat_i[7:0];
    assign chip   = adr[0];
    assign rd_idx = psg_reg_idx_t'(adr[3:1]);
    assign req    = cyc & stb;
    // Command taken on the ack edge, host still holds the request
    assign wr     = req & we & ack & (adr[3:1] == PSG_CMD_IDX);

    // One ack per request, drops for a cycle even with stb held
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req & ~ack;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int c = 0; c < 2; c++) begin
                for (int v = 0; v < 3; v++) begin
                    period[c][v] <= '0;
                end
                for (int v = 0; v < 4; v++) begin
                    att[c][v] <= '1;                // Muted
                end
                nctrl[c]    <= '0;
                lat_chan[c] <= '0;
                lat_type[c] <= PSG_TYPE_PER;
            end
            nwr <= 2'b00;
        end else begin
            nwr <= 2'b00;
            if (wr) begin
                if (cmd.lat.latch) begin
                    lat_chan[chip] <= cmd.lat.chan;
                    lat_type[chip] <= cmd.lat.typ;
                    if (cmd.lat.typ == PSG_TYPE_ATT) begin
                        att[chip][cmd.lat.chan] <= cmd.lat.data;
                    end else if (cmd.lat.chan == PSG_CHAN_NOISE) begin
                        nctrl[chip] <= cmd.lat.data[2:0];
                        nwr[chip]   <= 1'b1;    // Restart the LFSR
                    end else begin
                        period[chip][cmd.lat.chan][3:0] <= cmd.lat.data;
                    end
                end else if (lat_type[chip] == PSG_TYPE_PER &&
                             lat_chan[chip] != PSG_CHAN_NOISE) begin
                    // Data byte finishes the tone period
                    period[chip][lat_chan[chip]][`PSG_PERIOD_W-1:4] <= cmd.dat.data;
                end
            end
        end
    end

    // Readback, unused upper bits stay zero
    always_comb begin
        rd_data = '0;
        case (rd_idx)
            REG_TONE0_PER:  rd_data[`PSG_PERIOD_W-1:0] = period[chip][0];
            REG_TONE0_ATT:  rd_data[`PSG_ATT_W-1:0]    = att[chip][0];
            REG_TONE1_PER:  rd_data[`PSG_PERIOD_W-1:0] = period[chip][1];
            REG_TONE1_ATT:  rd_data[`PSG_ATT_W-1:0]    = att[chip][1];
            REG_TONE2_PER:  rd_data[`PSG_PERIOD_W-1:0] = period[chip][2];
            REG_TONE2_ATT:  rd_data[`PSG_ATT_W-1:0]    = att[chip][2];
            REG_NOISE_CTRL: rd_data[2:0]               = nctrl[chip];
            REG_NOISE_ATT:  rd_data[`PSG_ATT_W-1:0]    = att[chip][3];
            default:        rd_data = '0;
        endcase
    end

    // Sampled with the rising ack
    always_ff @(posedge clk) begin
        if (req && !ack) begin
            dat_o <= rd_data;
        end
    end

    assign period0_l    = period[0][0];
    assign period1_l    = period[0][1];
    assign period2_l    = period[0][2];
    assign att0_l       = att[0][0];
    assign att1_l       = att[0][1];
    assign att2_l       = att[0][2];
    assign att3_l       = att[0][3];
    assign noise_ctrl_l = nctrl[0];
    assign noise_wr_l   = nwr[0];

    assign period0_r    = period[1][0];
    assign period1_r    = period[1][1];
    assign period2_r    = period[1][2];
    assign att0_r       = att[1][0];
    assign att1_r       = att[1][1];
    assign att2_r       = att[1][2];
    assign att3_r       = att[1][3];
    assign noise_ctrl_r = nctrl[1];
    assign noise_wr_r   = nwr[1];

endmodule

`default_nettype wire

// ==== source/psg_audio_pkg.sv ====
`default_nettype none

`include "psg_settings.svh"

package psg_audio_pkg;

    typedef logic signed [`PSG_SAMPLE_W-1:0] psg_sample_t;  // One side, four voices summed
    typedef logic signed [9:0]               psg_level_t;   // One voice after sign
    typedef logic [8:0]                      psg_amp_t;

    // Full scale 511, minus 2 dB per attenuation step
    // Step 15 mutes the voice
    localparam psg_amp_t psg_att_amp [16] = '{
        9'd511, 9'd406, 9'd322, 9'd256,
        9'd203, 9'd162, 9'd128, 9'd102,
        9'd81,  9'd64,  9'd51,  9'd41,
        9'd32,  9'd26,  9'd20,  9'd0
    };

endpackage

`default_nettype wire

// ==== source/psg_reg_pkg.sv ====
`default_nettype none

package psg_reg_pkg;

    // Latch byte: 1 cc t dddd
    typedef struct packed {
        logic       latch;    // Set on a latch byte
        logic [1:0] chan;     // 3 is the noise channel
        logic       typ;      // 0 period or control, 1 attenuation
        logic [3:0] data;
    } psg_latch_t;

    // Data byte: 0 x dddddd
    typedef struct packed {
        logic       latch;
        logic       unused;
        logic [5:0] data;     // High period bits
    } psg_data_t;

    // Same bus byte seen both ways, bit 7 tells which view applies
    typedef union packed {
        psg_latch_t lat;
        psg_data_t  dat;
    } psg_cmd_t;

    // Readback order on adr[3:1]
    typedef enum logic [2:0] {
        REG_TONE0_PER, REG_TONE0_ATT,
        REG_TONE1_PER, REG_TONE1_ATT,
        REG_TONE2_PER, REG_TONE2_ATT,
        REG_NOISE_CTRL, REG_NOISE_ATT
    } psg_reg_idx_t;

    localparam logic [2:0] PSG_CMD_IDX    = 3'd0;  // Only index that takes writes
    localparam logic       PSG_TYPE_PER   = 1'b0;
    localparam logic       PSG_TYPE_ATT   = 1'b1;
    localparam logic [1:0] PSG_CHAN_NOISE = 2'd3;

endpackage

`default_nettype wire

// ==== source/psg_settings.svh ====
`ifndef PSG_SETTINGS_SVH
`define PSG_SETTINGS_SVH

// Tone period width, low 4 bits from a latch byte and the rest from a data byte
`define PSG_PERIOD_W 10

`define PSG_ATT_W 4        // Attenuation, 2 dB steps, 15 is off

`define PSG_SAMPLE_W 12    // Signed mixer output per side

// Noise shift register
`define PSG_LFSR_W 15

// cen pulses per voice tick
`define PSG_PRESCALE 16

// Wishbone port sizes
`define PSG_WB_DW 16
`define PSG_WB_AW 4        // Bit 0 picks the chip, bits 3..1 the register

`endif
